//--- rtl/pe.sv
module pe
    import tpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              tile_clear,
    input  logic              feed_en,
    input  logic [DATA_W-1:0] west,
    input  logic [DATA_W-1:0] north,
    output logic [DATA_W-1:0] east,
    output logic [DATA_W-1:0] south,
    output logic [ACC_W-1:0]  acc
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc   <= '0;
            east  <= '0;
            south <= '0;
        end else if (tile_clear) begin
            acc   <= '0;
            east  <= '0;
            south <= '0;
        end else if (feed_en) begin
            // unsigned MAC, operands forwarded a cycle later
            acc   <= acc + ACC_W'(west) * ACC_W'(north);
            east  <= west;
            south <= north;
        end
    end

endmodule

//--- rtl/pe_array.sv
module pe_array
    import tpu_pkg::*;
#(
    parameter int ARRAY_DIM = ARRAY_DIM_DEFAULT
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     tile_clear,
    input  logic                                     feed_en,
    input  logic [ARRAY_DIM*DATA_W-1:0]              row_in,
    input  logic [ARRAY_DIM*DATA_W-1:0]              col_in,
    output logic [ARRAY_DIM-1:0][ARRAY_DIM*ACC_W-1:0] rows
);

    // h runs east along a row, v runs south down a column
    logic [DATA_W-1:0] h [ARRAY_DIM][ARRAY_DIM+1];
    logic [DATA_W-1:0] v [ARRAY_DIM+1][ARRAY_DIM];

    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_edge
        assign h[i][0] = row_in[(ARRAY_DIM-1-i)*DATA_W +: DATA_W];
        assign v[0][i] = col_in[(ARRAY_DIM-1-i)*DATA_W +: DATA_W];
    end

    for (genvar r = 0; r < ARRAY_DIM; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_DIM; c++) begin : g_col
            pe u_pe (
                .clk        (clk),
                .rst_n      (rst_n),
                .tile_clear (tile_clear),
                .feed_en    (feed_en),
                .west       (h[r][c]),
                .north      (v[r][c]),
                .east       (h[r][c+1]),
                .south      (v[r+1][c]),
                // column 0 lands in the top bits
                .acc        (rows[r][(ARRAY_DIM-1-c)*ACC_W +: ACC_W])
            );
        end
    end

endmodule

//--- rtl/result_writer.sv
module result_writer
    import tpu_pkg::*;
#(
    parameter int ARRAY_DIM = ARRAY_DIM_DEFAULT
) (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      job_start,
    input  logic                                      drain_start,
    input  logic [$clog2(ARRAY_DIM + 1)-1:0]          drain_rows,
    input  logic [ARRAY_DIM-1:0][ARRAY_DIM*ACC_W-1:0] rows,
    output logic                                      c_wr_en,
    output logic [IDX_W-1:0]                          c_index,
    output logic [ARRAY_DIM*ACC_W-1:0]                c_data,
    output logic                                      drain_done
);
    localparam int CNT_W = $clog2(ARRAY_DIM + 1);

    logic             active;
    logic [CNT_W-1:0] row_cnt;
    logic [CNT_W-1:0] row_total;

    assign c_wr_en    = active;
    assign c_data     = rows[row_cnt];
    assign drain_done = active && (row_cnt == row_total - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active    <= 1'b0;
            row_cnt   <= '0;
            row_total <= '0;
        end else if (drain_start) begin
            active    <= 1'b1;
            row_cnt   <= '0;
            row_total <= drain_rows;
        end else if (active) begin
            row_cnt <= row_cnt + 1'b1;
            if (drain_done) active <= 1'b0;
        end
    end

    // C words are written back to back across tiles of one job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            c_index <= '0;
        end else if (job_start) begin
            c_index <= '0;
        end else if (active) begin
            c_index <= c_index + 1'b1;
        end
    end

endmodule

//--- rtl/skew_feeder.sv
module skew_feeder
    import tpu_pkg::*;
#(
    parameter int ARRAY_DIM = ARRAY_DIM_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         tile_clear,
    input  logic                         feed_en,
    input  logic                         word_valid,
    input  logic [ARRAY_DIM*DATA_W-1:0]  lane_word,
    output logic [ARRAY_DIM*DATA_W-1:0]  skewed
);

    // lane i sits at the top of the word for i = 0
    for (genvar i = 0; i < ARRAY_DIM; i++) begin : g_lane
        logic [DATA_W-1:0] din;

        // zeros once the K words are used up
        assign din = word_valid ? lane_word[(ARRAY_DIM-1-i)*DATA_W +: DATA_W] : '0;

        if (i == 0) begin : g_direct
            assign skewed[(ARRAY_DIM-1)*DATA_W +: DATA_W] = din;
        end else begin : g_delay
            logic [DATA_W-1:0] stage [i];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int s = 0; s < i; s++) stage[s] <= '0;
                end else if (tile_clear) begin
                    for (int s = 0; s < i; s++) stage[s] <= '0;
                end else if (feed_en) begin
                    stage[0] <= din;
                    for (int s = 1; s < i; s++) stage[s] <= stage[s-1];
                end
            end

            assign skewed[(ARRAY_DIM-1-i)*DATA_W +: DATA_W] = stage[i-1];
        end
    end

endmodule

//--- rtl/tile_controller.sv
module tile_controller
    import tpu_pkg::*;
#(
    parameter int ARRAY_DIM = ARRAY_DIM_DEFAULT
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  in_valid,
    input  logic [DIM_W-1:0]                      k,
    input  logic [DIM_W-1:0]                      m,
    input  logic [DIM_W-1:0]                      n,
    input  logic                                  drain_done,
    output logic                                  busy,
    output logic [IDX_W-1:0]                      a_index,
    output logic [IDX_W-1:0]                      b_index,
    output logic                                  job_start,
    output logic                                  tile_clear,
    output logic                                  feed_en,
    output logic                                  word_valid,
    output logic                                  drain_start,
    output logic [$clog2(ARRAY_DIM + 1)-1:0]      drain_rows
);
    localparam int CNT_W = $clog2(ARRAY_DIM + 1);

    ctrl_state_t       state;
    logic [DIM_W-1:0]  k_reg;
    logic [DIM_W-1:0]  m_reg;
    logic [DIM_W-1:0]  n_reg;
    logic [DIM_W-1:0]  row_blk;
    logic [DIM_W-1:0]  col_blk;
    logic [IDX_W-1:0]  step;
    logic [DIM_W:0]    row_blocks;
    logic [DIM_W:0]    col_blocks;
    logic [IDX_W-1:0]  feed_len;
    logic [CNT_W-1:0]  m_tail;
    logic              accept;
    logic              last_step;
    logic              last_row_blk;
    logic              last_col_blk;
    logic              last_tile;

    // ceiling divisions give the tile grid
    assign row_blocks = ({1'b0, m_reg} + (DIM_W + 1)'(ARRAY_DIM - 1)) / (DIM_W + 1)'(ARRAY_DIM);
    assign col_blocks = ({1'b0, n_reg} + (DIM_W + 1)'(ARRAY_DIM - 1)) / (DIM_W + 1)'(ARRAY_DIM);

    // K words plus the skew through both array dimensions
    assign feed_len  = IDX_W'(k_reg) + IDX_W'(2 * (ARRAY_DIM - 1) + 1);
    assign last_step = (step == feed_len - 1'b1);

    assign last_row_blk = ({1'b0, row_blk} == row_blocks - 1'b1);
    assign last_col_blk = ({1'b0, col_blk} == col_blocks - 1'b1);
    assign last_tile    = last_row_blk && last_col_blk;

    assign accept    = in_valid && (state == IDLE);
    assign job_start = accept;

    // clear ahead of the first tile and between tiles
    assign tile_clear = accept || ((state == DRAIN) && drain_done && !last_tile);

    assign feed_en     = (state == FEED);
    assign word_valid  = feed_en && (step < IDX_W'(k_reg));
    assign drain_start = feed_en && last_step;

    // a short last row block writes only the leftover rows
    assign m_tail     = CNT_W'(m_reg % ARRAY_DIM);
    assign drain_rows = (last_row_blk && m_tail != '0) ? m_tail : CNT_W'(ARRAY_DIM);

    assign a_index = IDX_W'(row_blk) * IDX_W'(k_reg) + step;
    assign b_index = IDX_W'(col_blk) * IDX_W'(k_reg) + step;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            busy    <= 1'b0;
            k_reg   <= '0;
            m_reg   <= '0;
            n_reg   <= '0;
            row_blk <= '0;
            col_blk <= '0;
            step    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        k_reg   <= k;
                        m_reg   <= m;
                        n_reg   <= n;
                        row_blk <= '0;
                        col_blk <= '0;
                        step    <= '0;
                        busy    <= 1'b1;
                        state   <= FEED;
                    end
                end
                FEED: begin
                    if (last_step) begin
                        state <= DRAIN;
                    end else begin
                        step <= step + 1'b1;
                    end
                end
                DRAIN: begin
                    if (drain_done) begin
                        step <= '0;
                        if (last_tile) begin
                            state <= DONE;
                        end else begin
                            state <= FEED;
                            // row blocks inner, column blocks outer
                            if (last_row_blk) begin
                                row_blk <= '0;
                                col_blk <= col_blk + 1'b1;
                            end else begin
                                row_blk <= row_blk + 1'b1;
                            end
                        end
                    end
                end
                DONE: begin
                    busy  <= 1'b0;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- rtl/tpu_pkg.sv
package tpu_pkg;

    // operand and accumulator widths
    localparam int DATA_W = 8;
    localparam int ACC_W  = 32;

    // job dimensions K, M and N
    localparam int DIM_W = 8;

    // word address into buffers A, B and C
    localparam int IDX_W = 16;

    // edge of the systolic array
    localparam int ARRAY_DIM_DEFAULT = 4;

    // per-tile sequencing of the controller
    typedef enum logic [1:0] {
        IDLE,
        FEED,
        DRAIN,
        DONE
    } ctrl_state_t;

endpackage

//--- rtl/tpu_top.sv
module tpu_top
    import tpu_pkg::*;
#(
    parameter int ARRAY_DIM = ARRAY_DIM_DEFAULT
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [DIM_W-1:0]             k,
    input  logic [DIM_W-1:0]             m,
    input  logic [DIM_W-1:0]             n,
    output logic                         busy,
    output logic [IDX_W-1:0]             a_index,
    input  logic [ARRAY_DIM*DATA_W-1:0]  a_data,
    output logic [IDX_W-1:0]             b_index,
    input  logic [ARRAY_DIM*DATA_W-1:0]  b_data,
    output logic                         c_wr_en,
    output logic [IDX_W-1:0]             c_index,
    output logic [ARRAY_DIM*ACC_W-1:0]   c_data
);
    localparam int CNT_W = $clog2(ARRAY_DIM + 1);

    logic                                          job_start;
    logic                                          tile_clear;
    logic                                          feed_en;
    logic                                          word_valid;
    logic                                          drain_start;
    logic                                          drain_done;
    logic [CNT_W-1:0]                              drain_rows;
    logic [ARRAY_DIM*DATA_W-1:0]                   a_skewed;
    logic [ARRAY_DIM*DATA_W-1:0]                   b_skewed;
    logic [ARRAY_DIM-1:0][ARRAY_DIM*ACC_W-1:0]     acc_rows;

    tile_controller #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .k           (k),
        .m           (m),
        .n           (n),
        .drain_done  (drain_done),
        .busy        (busy),
        .a_index     (a_index),
        .b_index     (b_index),
        .job_start   (job_start),
        .tile_clear  (tile_clear),
        .feed_en     (feed_en),
        .word_valid  (word_valid),
        .drain_start (drain_start),
        .drain_rows  (drain_rows)
    );

    // A enters from the west, one row per lane
    skew_feeder #(
        .ARRAY_DIM (ARRAY_DIM)
    ) a_feeder (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile_clear (tile_clear),
        .feed_en    (feed_en),
        .word_valid (word_valid),
        .lane_word  (a_data),
        .skewed     (a_skewed)
    );

    // B enters from the north, one column per lane
    skew_feeder #(
        .ARRAY_DIM (ARRAY_DIM)
    ) b_feeder (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile_clear (tile_clear),
        .feed_en    (feed_en),
        .word_valid (word_valid),
        .lane_word  (b_data),
        .skewed     (b_skewed)
    );

    pe_array #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .tile_clear (tile_clear),
        .feed_en    (feed_en),
        .row_in     (a_skewed),
        .col_in     (b_skewed),
        .rows       (acc_rows)
    );

    result_writer #(
        .ARRAY_DIM (ARRAY_DIM)
    ) u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .job_start   (job_start),
        .drain_start (drain_start),
        .drain_rows  (drain_rows),
        .rows        (acc_rows),
        .c_wr_en     (c_wr_en),
        .c_index     (c_index),
        .c_data      (c_data),
        .drain_done  (drain_done)
    );

endmodule

//--- tests/tpu_properties.sv
module tpu_properties
    import tpu_pkg::*;
(
    input logic             clk,
    input logic             rst_n,
    input logic             in_valid,
    input logic             busy,
    input logic             c_wr_en,
    input logic [IDX_W-1:0] c_index
);

    // writes only inside a job
    assert property (@(posedge clk) disable iff (!rst_n) c_wr_en |-> busy)
        else $error("c_wr_en high while busy is low");

    // a new job only while idle
    assert property (@(posedge clk) disable iff (!rst_n) in_valid |-> !busy)
        else $error("in_valid arrived while busy");

    // back to back rows go to adjacent C words
    assert property (@(posedge clk) disable iff (!rst_n)
        c_wr_en ##1 c_wr_en |-> c_index == IDX_W'($past(c_index) + 1'b1))
        else $error("c_index did not step by one between writes");

    // no job starts on the first edge out of reset
    assert property (@(posedge clk) $rose(rst_n) |=> !busy)
        else $error("busy high right after reset release");

endmodule

bind tpu_top tpu_properties props (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .busy     (busy),
    .c_wr_en  (c_wr_en),
    .c_index  (c_index)
);

//--- tests/tpu_tb.sv
module tpu_tb
    import tpu_pkg::*;
;
    localparam int ARRAY_DIM = ARRAY_DIM_DEFAULT;
    localparam int PERIOD    = 100;
    localparam int NUM_JOBS  = 2;
    localparam int SEED      = 39039;
    localparam int MAX_GAP   = 8;
    localparam int LANE_W    = ARRAY_DIM * DATA_W;
    localparam int ROW_W     = ARRAY_DIM * ACC_W;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic [DIM_W-1:0]  k;
    logic [DIM_W-1:0]  m;
    logic [DIM_W-1:0]  n;
    logic              busy;
    logic [IDX_W-1:0]  a_index;
    logic [IDX_W-1:0]  b_index;
    logic [LANE_W-1:0] a_data;
    logic [LANE_W-1:0] b_data;
    logic              c_wr_en;
    logic [IDX_W-1:0]  c_index;
    logic [ROW_W-1:0]  c_data;

    logic [ROW_W-1:0]  testdata [0:63];
    logic [LANE_W-1:0] a_mem [0:255];
    logic [LANE_W-1:0] b_mem [0:255];
    logic [ROW_W-1:0]  c_mem [0:255];
    int                gaps [NUM_JOBS];
    int                c_writes;
    int                limit_cycles = 0;

    tpu_top #(
        .ARRAY_DIM (ARRAY_DIM)
    ) uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .k        (k),
        .m        (m),
        .n        (n),
        .busy     (busy),
        .a_index  (a_index),
        .a_data   (a_data),
        .b_index  (b_index),
        .b_data   (b_data),
        .c_wr_en  (c_wr_en),
        .c_index  (c_index),
        .c_data   (c_data)
    );

    // A and B answer combinationally
    assign a_data = a_mem[a_index];
    assign b_data = b_mem[b_index];

    task automatic check_value(input string name, input logic [ROW_W-1:0] actual,
                               input logic [ROW_W-1:0] expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int block_count(input int len);
        return (len + ARRAY_DIM - 1) / ARRAY_DIM;
    endfunction

    // worst case per tile plus gaps, reset and job turnaround
    function automatic int budget_cycles();
        int ptr;
        int total;
        int kk;
        int mm;
        int rb;
        int cb;
        ptr = 0;
        total = 16;
        for (int j = 0; j < NUM_JOBS; j++) begin
            kk = testdata[ptr][23:16];
            mm = testdata[ptr][15:8];
            rb = block_count(mm);
            cb = block_count(testdata[ptr][7:0]);
            total += rb * cb * (kk + 2 * ARRAY_DIM + 8) + gaps[j] + 4;
            ptr += 1 + (rb + cb) * kk + cb * mm;
        end
        return total;
    endfunction

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("timeout: the jobs did not finish within %0d cycles", limit_cycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    // C buffer model sampled half a cycle ahead of each write edge
    always @(negedge clk) begin
        if (rst_n && c_wr_en) begin
            check_value("busy", busy, 1'b1);
            check_value("c_index", c_index, c_writes);
            c_mem[c_index] = c_data;
            c_writes++;
        end
    end

    initial begin
        int ptr;
        int kk;
        int mm;
        int nn;
        int a_words;
        int b_words;
        int c_rows;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        k        = '0;
        m        = '0;
        n        = '0;
        c_writes = 0;
        // words outside a job carry an address pattern
        for (int i = 0; i < 256; i++) begin
            a_mem[i] = {ARRAY_DIM{i[7:0]}};
            b_mem[i] = {ARRAY_DIM{~i[7:0]}};
        end
        void'($urandom(SEED));
        $readmemh("tests/tpu_testdata.txt", testdata);
        for (int j = 0; j < NUM_JOBS; j++) begin
            gaps[j] = 1 + ($urandom % MAX_GAP);
        end
        limit_cycles = budget_cycles();
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        ptr = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            kk = testdata[ptr][23:16];
            mm = testdata[ptr][15:8];
            nn = testdata[ptr][7:0];
            a_words = block_count(mm) * kk;
            b_words = block_count(nn) * kk;
            c_rows  = block_count(nn) * mm;
            for (int i = 0; i < a_words; i++) begin
                a_mem[i] = testdata[ptr + 1 + i][LANE_W-1:0];
            end
            for (int i = 0; i < b_words; i++) begin
                b_mem[i] = testdata[ptr + 1 + a_words + i][LANE_W-1:0];
            end
            for (int i = 0; i < 256; i++) begin
                c_mem[i] = 'x;
            end
            c_writes = 0;
            // no busy and no writes while idle between jobs
            repeat (gaps[j]) begin
                @(negedge clk);
                check_value("busy", busy, 1'b0);
                check_value("c_wr_en", c_wr_en, 1'b0);
            end
            in_valid = 1'b1;
            k = DIM_W'(kk);
            m = DIM_W'(mm);
            n = DIM_W'(nn);
            @(negedge clk);
            in_valid = 1'b0;
            check_value("busy", busy, 1'b1);
            while (busy) begin
                @(negedge clk);
            end
            check_value("c_writes", c_writes, c_rows);
            for (int i = 0; i < c_rows; i++) begin
                check_value($sformatf("c_mem[%0d]", i), c_mem[i],
                            testdata[ptr + 1 + a_words + b_words + i]);
            end
            ptr += 1 + a_words + b_words + c_rows;
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- tests/tpu_testdata.txt
// per job: header 00KKMMNN, then A words, B words, expected C rows
// lane and column 0 are the leftmost digits of each word
// job 0, K=3 M=4 N=4
030404
010407ff
0205080b
0306090c
ff000203
02010004
05030100
00000112_0000000b_00000005_0000000b
00000424_00000017_0000000e_00000020
00000736_00000023_00000017_00000035
0000fe53_0000002f_0000020a_00000329
// job 1, K=2 M=5 N=6, two column blocks and a one-row tail
020506
01030507
02040608
09000000
0a000000
01020304
0708090a
05060000
0b0c0000
0000000f_00000012_00000015_00000018
0000001f_00000026_0000002d_00000034
0000002f_0000003a_00000045_00000050
0000003f_0000004e_0000005d_0000006c
0000004f_00000062_00000075_00000088
0000001b_0000001e_00000000_00000000
0000003b_00000042_00000000_00000000
0000005b_00000066_00000000_00000000
0000007b_0000008a_00000000_00000000
0000009b_000000ae_00000000_00000000

//--- verilog.f
rtl/tpu_pkg.sv
rtl/pe.sv
rtl/pe_array.sv
rtl/skew_feeder.sv
rtl/tile_controller.sv
rtl/result_writer.sv
rtl/tpu_top.sv
tests/tpu_properties.sv
tests/tpu_tb.sv
